//--- Bender.yml
package:
  name: pwm

sources:
  - include_dirs:
      - common
    files:
      - common/pwm_pkg.sv
      - source/addsub.sv
      - preconditioner/pwm_preconditioner.sv
      - source/pwm_param_bank.sv
      - source/pwm_generator.sv
      - source/pwm_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - sim/tb_pwm_top.sv

//--- common/pwm_pkg.sv
// pwm package
// value, channel index, channel setting and edge pair types used
// between the parameter bank, preconditioner and generator

`include "pwm_settings.svh"

package pwm_pkg;

  // unsigned counter / edge value
  typedef logic [`PWM_WIDTH-1:0] pwm_value_t;

  // channel number
  typedef logic [$clog2(`PWM_CHANNELS)-1:0] chan_index_t;

  // per-channel setting as written by software
  typedef struct packed {
    pwm_value_t cycle;
    pwm_value_t duty;
    pwm_value_t phase;
  } chan_setting_t;

  // edge positions inside one cycle
  typedef struct packed {
    pwm_value_t rise;
    pwm_value_t fall;
  } edge_pair_t;

endpackage

//--- common/pwm_settings.svh
// pwm settings
// channel count, value width and add/sub pipeline depth shared by
// the package and the RTL modules

`ifndef PWM_SETTINGS_SVH
`define PWM_SETTINGS_SVH

// number of independent pwm channels
`define PWM_CHANNELS 8

// width of cycle, duty, phase and edge values
`define PWM_WIDTH 13

// register stages inside addsub
`define PWM_ADDSUB_LATENCY 2

`endif

//--- flist.f
+incdir+common
common/pwm_pkg.sv
source/addsub.sv
preconditioner/pwm_preconditioner.sv
source/pwm_param_bank.sv
source/pwm_generator.sv
source/pwm_top.sv
sim/tb_pwm_top.sv

//--- preconditioner/pwm_preconditioner.sv
// pwm preconditioner
// walks the channel snapshot one channel per cycle and turns cycle,
// duty and phase into rise/fall edges folded into 0..cycle-1.
// all edges are published together with a one-cycle edges_valid

`include "pwm_settings.svh"

module pwm_preconditioner import pwm_pkg::*; (
  input  logic          CLK,
  input  logic          rst,
  input  logic          start,
  input  chan_setting_t settings [`PWM_CHANNELS],
  output edge_pair_t    edges [`PWM_CHANNELS],
  output logic          edges_valid,
  output logic          busy
);

  localparam int nch = `PWM_CHANNELS;
  localparam int w = `PWM_WIDTH;
  localparam int ew = w + 2;  // room for sign and 2x cycle
  localparam int lat = `PWM_ADDSUB_LATENCY;
  localparam int fold_tap = 2 * lat + 1;
  localparam int cw = $clog2(nch + 3 * (lat + 1));

  typedef enum logic [1:0] {
    WAITING,
    RUN,
    DONE
  } state_t;

  state_t state;

  logic [cw-1:0] feed_cnt, sum_cnt, fold_cnt, set_cnt;
  chan_index_t feed_ch, set_ch;
  chan_setting_t cur;

  logic signed [ew-1:0] cycle_buf [fold_tap + 1];
  logic signed [ew-1:0] duty_buf [lat + 1];

  logic signed [ew-1:0] a_phase, b_phase, s_phase;
  logic signed [ew-1:0] a_duty_r, b_duty_r, s_duty_r;
  logic signed [ew-1:0] a_rise, b_rise, s_rise;
  logic signed [ew-1:0] a_fall, b_fall, s_fall;
  logic signed [ew-1:0] a_fold_rise, b_fold_rise, s_fold_rise;
  logic signed [ew-1:0] a_fold_fall, b_fold_fall, s_fold_fall;
  logic fold_rise_add;

  edge_pair_t res_buf [nch];

  assign feed_ch = (feed_cnt < cw'(nch)) ? chan_index_t'(feed_cnt) : '0;
  assign set_ch = chan_index_t'(set_cnt);
  assign cur = settings[feed_ch];

  addsub #(.width(ew)) sub_phase (
    .CLK(CLK), .a(a_phase), .b(b_phase), .add(1'b0), .s(s_phase)
  );
  addsub #(.width(ew)) add_duty_r (
    .CLK(CLK), .a(a_duty_r), .b(b_duty_r), .add(1'b1), .s(s_duty_r)
  );
  addsub #(.width(ew)) sub_rise (
    .CLK(CLK), .a(a_rise), .b(b_rise), .add(1'b0), .s(s_rise)
  );
  addsub #(.width(ew)) add_fall (
    .CLK(CLK), .a(a_fall), .b(b_fall), .add(1'b1), .s(s_fall)
  );
  addsub #(.width(ew)) fold_rise (
    .CLK(CLK), .a(a_fold_rise), .b(b_fold_rise), .add(fold_rise_add), .s(s_fold_rise)
  );
  addsub #(.width(ew)) fold_fall (
    .CLK(CLK), .a(a_fold_fall), .b(b_fold_fall), .add(1'b0), .s(s_fold_fall)
  );

  // ======================================================================
  // datapath, free running
  // ======================================================================
  always_ff @(posedge CLK) begin
    duty_buf[0] <= {2'b00, cur.duty};
    cycle_buf[0] <= {2'b00, cur.cycle};
    for (int k = 1; k <= lat; k++) begin
      duty_buf[k] <= duty_buf[k-1];
    end
    for (int k = 1; k <= fold_tap; k++) begin
      cycle_buf[k] <= cycle_buf[k-1];
    end

    // base = cycle - phase, ceil(duty/2)
    a_phase <= {2'b00, cur.cycle};
    b_phase <= {2'b00, cur.phase};
    a_duty_r <= {3'b000, cur.duty[w-1:1]};
    b_duty_r <= {{(ew - 1){1'b0}}, cur.duty[0]};

    // rise = base - floor(duty/2), fall = base + ceil(duty/2)
    a_rise <= s_phase;
    b_rise <= {1'b0, duty_buf[lat][ew-1:1]};
    a_fall <= s_phase;
    b_fall <= s_duty_r;

    // fold back into 0..cycle-1
    a_fold_rise <= s_rise;
    if (s_rise < 0) begin
      b_fold_rise <= cycle_buf[fold_tap];
      fold_rise_add <= 1'b1;
    end else if (cycle_buf[fold_tap] <= s_rise) begin
      b_fold_rise <= cycle_buf[fold_tap];
      fold_rise_add <= 1'b0;
    end else begin
      b_fold_rise <= '0;
      fold_rise_add <= 1'b1;
    end
    a_fold_fall <= s_fall;
    b_fold_fall <= (cycle_buf[fold_tap] <= s_fall) ? cycle_buf[fold_tap] : '0;
  end

  always_ff @(posedge CLK) begin
    if (state == RUN && fold_cnt > lat) begin
      res_buf[set_ch].rise <= s_fold_rise[w-1:0];
      res_buf[set_ch].fall <= s_fold_fall[w-1:0];
    end
  end

  // ======================================================================
  // sequencer
  // ======================================================================
  always_ff @(posedge CLK) begin
    if (rst) begin
      state <= WAITING;
      feed_cnt <= '0;
      sum_cnt <= '0;
      fold_cnt <= '0;
      set_cnt <= '0;
      busy <= 1'b0;
      edges_valid <= 1'b0;
    end else begin
      edges_valid <= 1'b0;
      case (state)
        WAITING: begin
          if (start) begin
            feed_cnt <= '0;
            sum_cnt <= '0;
            fold_cnt <= '0;
            set_cnt <= '0;
            busy <= 1'b1;
            state <= RUN;
          end
        end
        RUN: begin
          feed_cnt <= feed_cnt + 1'b1;
          if (feed_cnt > lat) sum_cnt <= sum_cnt + 1'b1;  // first base ready
          if (sum_cnt > lat) fold_cnt <= fold_cnt + 1'b1;
          if (fold_cnt > lat) begin
            set_cnt <= set_cnt + 1'b1;
            if (set_cnt == cw'(nch - 1)) state <= DONE;
          end
        end
        DONE: begin
          edges_valid <= 1'b1;
          busy <= 1'b0;
          state <= WAITING;
        end
        default: state <= WAITING;
      endcase
    end
  end

  // publish all channels at once
  always_ff @(posedge CLK) begin
    if (rst) begin
      edges <= '{default: '0};
    end else if (state == DONE) begin
      edges <= res_buf;
    end
  end

endmodule

//--- sim/tb_pwm_top.sv
// pwm top testbench
// commits directed and random channel settings, predicts the edges with
// a reference function and pwm_out with a counter model, and compares
// pwm_out on every cycle once the first sync has gone out

`include "pwm_settings.svh"

module tb_pwm_top import pwm_pkg::*; ();

  localparam int nch = `PWM_CHANNELS;
  localparam int max_cycle = 1000;     // upper bound of random cycles
  localparam int commit_bound = 64;    // writes, commit and pipeline
  localparam int n_rounds = 16;
  localparam int limit = n_rounds * (commit_bound + 4 * max_cycle);

  logic CLK;
  logic rst;
  logic wr_en;
  chan_index_t wr_addr;
  chan_setting_t wr_data;
  logic commit;
  logic sync;
  logic [nch-1:0] pwm_out;
  logic busy;

  chan_setting_t live [nch];    // last values written per channel
  edge_pair_t pend [nch];       // expected edges of the accepted snapshot
  pwm_value_t pend_cyc [nch];
  edge_pair_t m_edge [nch];
  pwm_value_t m_cyc [nch];
  pwm_value_t m_cnt [nch];
  logic [nch-1:0] exp_out;
  logic check_en;
  string test_name;
  int errors;
  int checks;
  int cycles;
  logic [31:0] rng;

  pwm_top UUT (
    .CLK     (CLK),
    .rst     (rst),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .commit  (commit),
    .sync    (sync),
    .pwm_out (pwm_out),
    .busy    (busy)
  );

  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  // ======================================================================
  // reference and helpers
  // ======================================================================
  function automatic int unsigned lcg_next();
    rng = rng * 32'd1103515245 + 32'd12345;
    return (rng >> 16) & 32'h7fff;  // low bits of the lcg repeat quickly
  endfunction

  function automatic chan_setting_t make_setting(int cyc, int duty, int phase);
    chan_setting_t s;
    s.cycle = pwm_value_t'(cyc);
    s.duty = pwm_value_t'(duty);
    s.phase = pwm_value_t'(phase);
    return s;
  endfunction

  function automatic chan_setting_t random_setting();
    int cyc;
    cyc = 2 + int'(lcg_next() % (max_cycle - 1));
    return make_setting(cyc, int'(lcg_next() % cyc), int'(lcg_next() % cyc));
  endfunction

  // edge rule in signed arithmetic
  function automatic edge_pair_t ref_edges(chan_setting_t s);
    int cyc;
    int duty;
    int base;
    int rise;
    int fall;
    edge_pair_t e;
    cyc = int'(s.cycle);
    duty = int'(s.duty);
    base = cyc - int'(s.phase);
    rise = base - duty / 2;
    fall = base + (duty + 1) / 2;
    if (rise < 0) rise += cyc;
    else if (rise >= cyc) rise -= cyc;
    if (fall >= cyc) fall -= cyc;
    e.rise = pwm_value_t'(rise);
    e.fall = pwm_value_t'(fall);
    return e;
  endfunction

  function automatic logic in_window(pwm_value_t t, edge_pair_t e);
    if (e.rise <= e.fall) begin
      return t >= e.rise && t < e.fall;
    end
    return t >= e.rise || t < e.fall;  // wraps past the cycle end
  endfunction

  // expected edges of live[] and the longest cycle among them
  function automatic int take_snapshot();
    int longest;
    longest = 0;
    for (int ch = 0; ch < nch; ch++) begin
      pend[ch] = ref_edges(live[ch]);
      pend_cyc[ch] = live[ch].cycle;
      if (int'(live[ch].cycle) > longest) longest = int'(live[ch].cycle);
    end
    return longest;
  endfunction

  task automatic check(string name, logic [31:0] expected, logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic write_all();
    for (int ch = 0; ch < nch; ch++) begin
      @(posedge CLK);
      wr_en <= 1'b1;
      wr_addr <= chan_index_t'(ch);
      wr_data <= live[ch];
    end
    @(posedge CLK);
    wr_en <= 1'b0;
  endtask

  task automatic pulse_commit();
    commit <= 1'b1;
    @(posedge CLK);
    commit <= 1'b0;
  endtask

  task automatic wait_edges();
    @(posedge CLK);
    while (!UUT.edges_valid) @(posedge CLK);
  endtask

  task automatic pulse_sync();
    sync <= 1'b1;
    @(posedge CLK);
    sync <= 1'b0;
    check_en = 1'b1;
  endtask

  task automatic run_round(string name);
    int longest;
    test_name = name;
    longest = take_snapshot();
    write_all();
    pulse_commit();
    wait_edges();
    pulse_sync();
    repeat (3 * longest) @(posedge CLK);
  endtask

  // ======================================================================
  // output model and compare
  // ======================================================================
  always @(posedge CLK) begin
    if (rst) begin
      for (int i = 0; i < nch; i++) begin
        m_cnt[i] <= '0;
        m_cyc[i] <= '0;
        m_edge[i] <= '0;
      end
      exp_out <= '0;
    end else begin
      for (int i = 0; i < nch; i++) begin
        exp_out[i] <= in_window(m_cnt[i], m_edge[i]);  // one cycle late
        if (sync || int'(m_cnt[i]) + 1 >= int'(m_cyc[i])) m_cnt[i] <= '0;
        else m_cnt[i] <= m_cnt[i] + 1'b1;
        if (UUT.edges_valid) begin
          m_cyc[i] <= pend_cyc[i];
          m_edge[i] <= pend[i];
        end
      end
    end
  end

  always @(negedge CLK) begin
    if (check_en) check(test_name, exp_out, pwm_out);
  end

  always @(posedge CLK) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout after %0d cycles, edges_valid never came", limit);
      $display("checks: %0d, errors: %0d", checks, errors);
      $display("Errors found");
      $finish;
    end
  end

  // ======================================================================
  // stimulus
  // ======================================================================
  initial begin
    int longest;
    int high;
    rng = 32'd82;
    errors = 0;
    checks = 0;
    check_en = 1'b0;
    rst = 1'b1;
    wr_en = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    commit = 1'b0;
    sync = 1'b0;
    repeat (16) @(posedge CLK);
    rst <= 1'b0;

    for (int ch = 0; ch < nch; ch++) live[ch] = make_setting(20, 8, 0);
    run_round("centered pulse");
    high = 0;
    repeat (20) begin
      @(negedge CLK);
      high += pwm_out[0];
    end
    check("centered pulse high count", 8, high);

    for (int ch = 0; ch < nch; ch++) live[ch] = make_setting(100, 70 + 3 * ch, 92 + ch);
    run_round("negative rise wraps");
    for (int ch = 0; ch < nch; ch++) live[ch] = make_setting(60 + ch, 50, 0);
    run_round("fall past cycle");
    for (int ch = 0; ch < nch; ch++) live[ch] = make_setting(30 + ch, 0, 3 * ch);
    run_round("duty zero");

    for (int r = 0; r < 8; r++) begin
      for (int ch = 0; ch < nch; ch++) live[ch] = random_setting();
      run_round("random settings");
    end

    // second commit lands while the first one is still computing
    test_name = "writes while busy";
    for (int ch = 0; ch < nch; ch++) live[ch] = make_setting(40, 10, 5 + ch);
    longest = take_snapshot();
    write_all();
    pulse_commit();
    while (!busy) @(posedge CLK);
    for (int ch = 0; ch < nch; ch++) live[ch] = make_setting(24, 12, ch);
    write_all();
    commit <= 1'b1;
    @(posedge CLK);
    check("busy at second commit", 1, busy);
    commit <= 1'b0;
    wait_edges();
    pulse_sync();
    repeat (3 * longest) @(posedge CLK);
    run_round("commit after busy");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

//--- source/addsub.sv
// addsub
// signed adder/subtractor with two output register stages, so a
// result shows up exactly two cycles after its operands (DSP style)

module addsub #(
  parameter int width = 15
) (
  input  logic                    CLK,
  input  logic signed [width-1:0] a,
  input  logic signed [width-1:0] b,
  input  logic                    add,  // 1: a+b, 0: a-b
  output logic signed [width-1:0] s
);

  logic signed [width-1:0] s_q;

  // first stage holds the raw sum
  always_ff @(posedge CLK) begin
    if (add) begin
      s_q <= a + b;
    end else begin
      s_q <= a - b;
    end
  end

  // second stage, output register
  always_ff @(posedge CLK) begin
    s <= s_q;
  end

endmodule

//--- source/pwm_generator.sv
// pwm generator
// one free-running counter per channel wrapping at its cycle, compared
// against the held edge pair; outputs are registered

`include "pwm_settings.svh"

module pwm_generator import pwm_pkg::*; (
  input  logic                      CLK,
  input  logic                      rst,
  input  logic                      sync,
  input  chan_setting_t             settings [`PWM_CHANNELS],
  input  edge_pair_t                edges [`PWM_CHANNELS],
  input  logic                      edges_valid,
  output logic [`PWM_CHANNELS-1:0]  pwm_out
);

  logic [`PWM_CHANNELS-1:0] hi;

  for (genvar i = 0; i < `PWM_CHANNELS; i++) begin : gen_chan
    pwm_value_t cnt;
    pwm_value_t cyc;
    edge_pair_t edge_q;

    // cycle and edges switch together
    always_ff @(posedge CLK) begin
      if (rst) begin
        cyc <= '0;
        edge_q <= '0;
      end else if (edges_valid) begin
        cyc <= settings[i].cycle;
        edge_q <= edges[i];
      end
    end

    always_ff @(posedge CLK) begin
      if (rst) begin
        cnt <= '0;
      end else if (sync || cnt + 1'b1 >= cyc) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end

    // ordered window, or wrapped across the cycle end
    assign hi[i] = (edge_q.rise <= edge_q.fall) ?
                   (cnt >= edge_q.rise && cnt < edge_q.fall) :
                   (cnt >= edge_q.rise || cnt < edge_q.fall);
  end

  always_ff @(posedge CLK) begin
    if (rst) pwm_out <= '0;
    else pwm_out <= hi;
  end

endmodule

//--- source/pwm_param_bank.sv
// pwm parameter bank
// live per-channel setting registers written one channel at a time,
// plus a shadow snapshot taken on an accepted commit

`include "pwm_settings.svh"

module pwm_param_bank import pwm_pkg::*; (
  input  logic          CLK,
  input  logic          rst,
  input  logic          wr_en,
  input  chan_index_t   wr_addr,
  input  chan_setting_t wr_data,
  input  logic          commit,
  input  logic          busy,
  output chan_setting_t settings [`PWM_CHANNELS],
  output logic          start
);

  chan_setting_t live [`PWM_CHANNELS];
  logic take;

  // start still in flight counts as busy too
  assign take = commit && !busy && !start;

  // live registers
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      live[wr_addr] <= wr_data;
    end
  end

  // snapshot, held steady while the preconditioner reads it
  always_ff @(posedge CLK) begin
    if (take) begin
      settings <= live;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      start <= 1'b0;
    end else begin
      start <= take;  // one pulse per accepted commit
    end
  end

endmodule

//--- source/pwm_top.sv
// pwm top
// multi-channel pwm: parameter bank feeding the edge preconditioner,
// whose edges drive the per-channel generator

`include "pwm_settings.svh"

module pwm_top import pwm_pkg::*; (
  input  logic                      CLK,
  input  logic                      rst,
  input  logic                      wr_en,
  input  chan_index_t               wr_addr,
  input  chan_setting_t             wr_data,
  input  logic                      commit,
  input  logic                      sync,
  output logic [`PWM_CHANNELS-1:0]  pwm_out,
  output logic                      busy
);

  chan_setting_t settings [`PWM_CHANNELS];  // committed snapshot
  edge_pair_t edges [`PWM_CHANNELS];
  logic start;
  logic edges_valid;

  pwm_param_bank u_bank (
    .CLK      (CLK),
    .rst      (rst),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .commit   (commit),
    .busy     (busy),
    .settings (settings),
    .start    (start)
  );

  pwm_preconditioner u_precond (
    .CLK         (CLK),
    .rst         (rst),
    .start       (start),
    .settings    (settings),
    .edges       (edges),
    .edges_valid (edges_valid),
    .busy        (busy)
  );

  pwm_generator u_gen (
    .CLK         (CLK),
    .rst         (rst),
    .sync        (sync),
    .settings    (settings),
    .edges       (edges),
    .edges_valid (edges_valid),
    .pwm_out     (pwm_out)
  );

endmodule
